//--- design/c16_bus_pkg.sv
////////////////////
// C16 bus package
// Widths of the CPU bus and host download, loader credits and bank fields
////////////////////
package c16_bus_pkg;

	// CPU side
	typedef logic [15:0] addr_t;
	typedef logic [7:0] data_t;

	// Host download offset
	typedef logic [24:0] dl_addr_t;

	// Write-queue slots the PRG loader may hold at once
	localparam int LOADER_CREDITS = 2;
	typedef logic [1:0] credit_t;

	// One field of the Plus/4 bank register
	typedef enum logic [1:0] {
		BANK_BUILTIN = 2'd0,
		BANK_CART    = 2'd1,
		BANK_FUNC    = 2'd2,
		BANK_EMPTY   = 2'd3
	} bank_t;

endpackage

//--- design/c16_map_pkg.sv
////////////////////
// C16 memory map package
// Download indexes, ROM block numbers, address windows and BASIC pointers
////////////////////
package c16_map_pkg;

	// Host download indexes
	localparam logic [7:0] IDX_PRG = 8'h01;
	localparam logic [7:0] IDX_ROM = 8'h03;
	localparam logic [7:0] IDX_CRT = 8'h81;

	// Blocks of a ROM download, taken from offset bits 24..14
	localparam logic [10:0] BLK_KERNAL = 11'd1;
	localparam logic [10:0] BLK_BASIC  = 11'd2;
	localparam logic [10:0] BLK_FUNCL  = 11'd3;
	localparam logic [10:0] BLK_FUNCH  = 11'd4;

	// Blocks of a cartridge download
	localparam logic [10:0] BLK_CART_L = 11'd0;
	localparam logic [10:0] BLK_CART_H = 11'd1;

	localparam int ROM_AW = 14;

	////////////////////
	// CPU address map
	localparam c16_bus_pkg::addr_t LOW_ROM_BASE  = 16'h8000;
	localparam c16_bus_pkg::addr_t HIGH_ROM_BASE = 16'hC000;
	localparam logic [7:0] KERNAL_PAGE = 8'hFC;
	localparam c16_bus_pkg::addr_t IO_FIRST = 16'hFD00;
	localparam c16_bus_pkg::addr_t IO_LAST  = 16'hFF3F;
	localparam logic [11:0] BANK_REG_PAGE = 12'hFDD;
	localparam c16_bus_pkg::addr_t ROM_ON_ADDR  = 16'hFF3E;
	localparam c16_bus_pkg::addr_t ROM_OFF_ADDR = 16'hFF3F;

	// BASIC pointers patched after a PRG load, low byte at even entries
	localparam c16_bus_pkg::addr_t PTR_ADDR [0:7] = '{
		16'h002D, 16'h002E, 16'h002F, 16'h0030,
		16'h0031, 16'h0032, 16'h009D, 16'h009E
	};

	function automatic logic is_io(input c16_bus_pkg::addr_t a);
		return (a >= IO_FIRST) && (a <= IO_LAST);
	endfunction

	// Upper half of the map belongs to ROM while ROM is shown
	function automatic logic rom_window(input c16_bus_pkg::addr_t a, input logic rom_vis);
		return rom_vis && (a >= LOW_ROM_BASE);
	endfunction

endpackage

//--- design/cpu_bus_if.sv
////////////////////
// CPU access bus
// One request per cycle, seen by both RAM and ROM sides
////////////////////
`timescale 1ns/1ps

interface cpu_bus_if;
	import c16_bus_pkg::*;

	logic req;
	logic we;
	addr_t addr;
	data_t wdata;

	modport master (
		output req, we, addr, wdata
	);

	// Both memory sides only watch the request
	modport slave (
		input req, we, addr, wdata
	);

endinterface

//--- design/mem_req_if.sv
////////////////////
// Loader write requests
// Credit-based path from the PRG loader into the RAM write queue
////////////////////
`timescale 1ns/1ps

interface mem_req_if;
	import c16_bus_pkg::*;

	logic valid;
	addr_t addr;
	data_t data;
	// One pulse per queued write retired to RAM
	logic credit_ret;

	modport loader (
		output valid, addr, data,
		input credit_ret
	);

	modport arbiter (
		input valid, addr, data,
		output credit_ret
	);

endinterface

//--- design/prg_loader.sv
////////////////////
// PRG loader
// Writes a downloaded program at its load address, then patches
// the BASIC pointers with the end address
////////////////////
`timescale 1ns/1ps

module prg_loader (
	input  logic clk_sys,
	input  logic reset,
	input  logic dl_active_i,
	input  c16_bus_pkg::data_t dl_index_i,
	input  logic dl_valid_i,
	input  c16_bus_pkg::dl_addr_t dl_addr_i,
	input  c16_bus_pkg::data_t dl_data_i,
	output logic dl_wait_o,
	output logic busy_o,
	mem_req_if.loader req
);
	import c16_bus_pkg::*;
	import c16_map_pkg::*;

	addr_t load_addr;
	credit_t credits;
	logic prg_q;
	logic patching;
	logic [2:0] ptr_idx;

	logic prg_now;
	logic accept;
	logic data_wr;
	logic load_end;
	logic patch_wr;

	assign prg_now = dl_active_i && (dl_index_i == IDX_PRG);

	// Hold the host while no queue slot is free
	assign dl_wait_o = prg_now && ((credits == '0) || patching);
	assign accept = prg_now && dl_valid_i && !dl_wait_o;

	// First two bytes are the load address
	assign data_wr = accept && (dl_addr_i > dl_addr_t'(1));

	assign load_end = prg_q && !dl_active_i;
	assign patch_wr = patching && (credits != '0);

	assign req.valid = data_wr || patch_wr;
	assign req.addr = patching ? PTR_ADDR[ptr_idx] : load_addr;
	assign req.data = patching ? (ptr_idx[0] ? load_addr[15:8] : load_addr[7:0]) : dl_data_i;

	// Busy also covers writes still sitting in the arbiter queue
	assign busy_o = patching || load_end || (credits != credit_t'(LOADER_CREDITS));

	////////////////////
	// Credits and pointer walk
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			credits <= credit_t'(LOADER_CREDITS);
			prg_q <= 1'b0;
			patching <= 1'b0;
			ptr_idx <= '0;
		end else begin
			credits <= credits - credit_t'(req.valid) + credit_t'(req.credit_ret);
			prg_q <= prg_now;
			if (load_end) begin
				patching <= 1'b1;
				ptr_idx <= '0;
			end else if (patch_wr) begin
				ptr_idx <= ptr_idx + 3'd1;
				if (ptr_idx == 3'd7) begin
					patching <= 1'b0;
				end
			end
		end
	end

	// Running address, ends up as the end address of the program
	always_ff @(posedge clk_sys) begin
		if (accept && (dl_addr_i == dl_addr_t'(0))) begin
			load_addr[7:0] <= dl_data_i;
		end else if (accept && (dl_addr_i == dl_addr_t'(1))) begin
			load_addr[15:8] <= dl_data_i;
		end else if (data_wr) begin
			load_addr <= load_addr + 16'd1;
		end
	end

endmodule

//--- design/ram_arbiter.sv
////////////////////
// Main RAM arbiter
// 64 KB RAM shared by the CPU and the loader write queue
////////////////////
`timescale 1ns/1ps

module ram_arbiter (
	input  logic clk_sys,
	input  logic reset,
	cpu_bus_if.slave cpu,
	mem_req_if.arbiter req,
	output c16_bus_pkg::data_t rdata_o,
	output logic rom_vis_o
);
	import c16_bus_pkg::*;
	import c16_map_pkg::*;

	data_t ram [0:2**$bits(addr_t)-1];

	// Loader write queue
	addr_t q_addr [LOADER_CREDITS];
	data_t q_data [LOADER_CREDITS];
	logic [$clog2(LOADER_CREDITS)-1:0] wr_ptr;
	logic [$clog2(LOADER_CREDITS)-1:0] rd_ptr;
	credit_t q_count;

	logic rom_vis;
	logic rd_ram;
	data_t ram_q;

	logic cpu_rd;
	logic cpu_wr;
	logic retire;

	assign cpu_rd = cpu.req && !cpu.we;
	// I/O writes never land in RAM
	assign cpu_wr = cpu.req && cpu.we && !is_io(cpu.addr);

	// CPU owns the port, the queue drains in idle cycles
	assign retire = !cpu.req && (q_count != '0);
	assign req.credit_ret = retire;

	assign rom_vis_o = rom_vis;
	assign rdata_o = rd_ram ? ram_q : 8'hFF;

	always_ff @(posedge clk_sys) begin
		if (cpu_wr) begin
			ram[cpu.addr] <= cpu.wdata;
		end else if (retire) begin
			ram[q_addr[rd_ptr]] <= q_data[rd_ptr];
		end
		if (cpu_rd) begin
			ram_q <= ram[cpu.addr];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (req.valid) begin
			q_addr[wr_ptr] <= req.addr;
			q_data[wr_ptr] <= req.data;
		end
	end

	////////////////////
	// Queue pointers, ROM flag, read select
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_count <= '0;
			rom_vis <= 1'b1;
			rd_ram <= 1'b0;
		end else begin
			if (req.valid) begin
				wr_ptr <= (wr_ptr == LOADER_CREDITS - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (retire) begin
				rd_ptr <= (rd_ptr == LOADER_CREDITS - 1) ? '0 : rd_ptr + 1'b1;
			end
			q_count <= q_count + credit_t'(req.valid) - credit_t'(retire);

			if (cpu.req && cpu.we && (cpu.addr == ROM_ON_ADDR)) begin
				rom_vis <= 1'b1;
			end else if (cpu.req && cpu.we && (cpu.addr == ROM_OFF_ADDR)) begin
				rom_vis <= 1'b0;
			end

			// RAM answers only outside I/O and the shown ROM windows
			if (cpu_rd) begin
				rd_ram <= !is_io(cpu.addr) && !rom_window(cpu.addr, rom_vis);
			end
		end
	end

endmodule

//--- design/rom_bank.sv
////////////////////
// ROM bank
// ROM and cartridge arrays loaded by the host, Plus/4 banking
// and the ROM side of the CPU read
////////////////////
`timescale 1ns/1ps

module rom_bank (
	input  logic clk_sys,
	input  logic reset,
	input  logic model_i,
	input  c16_bus_pkg::data_t dl_index_i,
	input  logic dl_valid_i,
	input  c16_bus_pkg::dl_addr_t dl_addr_i,
	input  c16_bus_pkg::data_t dl_data_i,
	input  logic rom_vis_i,
	cpu_bus_if.slave cpu,
	output c16_bus_pkg::data_t rdata_o
);
	import c16_bus_pkg::*;
	import c16_map_pkg::*;

	typedef enum logic [2:0] {
		SLOT_NONE,
		SLOT_KERNAL,
		SLOT_BASIC,
		SLOT_FUNCL,
		SLOT_FUNCH,
		SLOT_CART_L,
		SLOT_CART_H
	} slot_e;

	data_t rom_mem [SLOT_KERNAL:SLOT_CART_H][0:2**ROM_AW-1];

	logic plus4;
	bank_t bank_lo;
	bank_t bank_hi;
	logic cart_l;
	logic cart_h;
	logic rd_hit;
	data_t rom_q;

	logic [10:0] dl_blk;
	logic cpu_rd;
	slot_e wr_slot;
	slot_e rd_slot;

	assign dl_blk = dl_addr_i[24:14];
	assign cpu_rd = cpu.req && !cpu.we;
	assign rdata_o = rd_hit ? rom_q : 8'hFF;

	// Download target
	always_comb begin
		wr_slot = SLOT_NONE;
		if (dl_valid_i && (dl_index_i == IDX_ROM)) begin
			case (dl_blk)
				BLK_KERNAL: wr_slot = SLOT_KERNAL;
				BLK_BASIC: wr_slot = SLOT_BASIC;
				BLK_FUNCL: wr_slot = SLOT_FUNCL;
				BLK_FUNCH: wr_slot = SLOT_FUNCH;
				default: wr_slot = SLOT_NONE;
			endcase
		end else if (dl_valid_i && (dl_index_i == IDX_CRT)) begin
			if (dl_blk == BLK_CART_L) begin
				wr_slot = SLOT_CART_L;
			end else if (dl_blk == BLK_CART_H) begin
				wr_slot = SLOT_CART_H;
			end
		end
	end

	////////////////////
	// Read decode
	always_comb begin
		rd_slot = SLOT_NONE;
		if (!is_io(cpu.addr) && rom_window(cpu.addr, rom_vis_i)) begin
			if (cpu.addr[15:8] == KERNAL_PAGE) begin
				rd_slot = SLOT_KERNAL;
			end else if (cpu.addr < HIGH_ROM_BASE) begin
				case (bank_lo)
					BANK_BUILTIN: rd_slot = SLOT_BASIC;
					BANK_CART: rd_slot = cart_l ? SLOT_CART_L : SLOT_NONE;
					BANK_FUNC: rd_slot = SLOT_FUNCL;
					BANK_EMPTY: rd_slot = SLOT_NONE;
					default: rd_slot = SLOT_NONE;
				endcase
			end else begin
				case (bank_hi)
					BANK_BUILTIN: rd_slot = SLOT_KERNAL;
					BANK_CART: rd_slot = cart_h ? SLOT_CART_H : SLOT_NONE;
					BANK_FUNC: rd_slot = SLOT_FUNCH;
					BANK_EMPTY: rd_slot = SLOT_NONE;
					default: rd_slot = SLOT_NONE;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_slot != SLOT_NONE) begin
			rom_mem[wr_slot][dl_addr_i[ROM_AW-1:0]] <= dl_data_i;
		end
		if (cpu_rd && (rd_slot != SLOT_NONE)) begin
			rom_q <= rom_mem[rd_slot][cpu.addr[ROM_AW-1:0]];
		end
	end

	// Model is taken while reset is held
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			plus4 <= model_i;
			bank_lo <= BANK_BUILTIN;
			bank_hi <= BANK_BUILTIN;
			cart_l <= 1'b0;
			cart_h <= 1'b0;
			rd_hit <= 1'b0;
		end else begin
			if (wr_slot == SLOT_CART_L) begin
				cart_l <= 1'b1;
			end
			if (wr_slot == SLOT_CART_H) begin
				cart_h <= 1'b1;
			end
			// Bank fields come from the address, not the data
			if (plus4 && cpu.req && cpu.we && (cpu.addr[15:4] == BANK_REG_PAGE)) begin
				bank_hi <= bank_t'(cpu.addr[3:2]);
				bank_lo <= bank_t'(cpu.addr[1:0]);
			end
			if (cpu_rd) begin
				rd_hit <= (rd_slot != SLOT_NONE);
			end
		end
	end

endmodule

//--- design/c16_mem_top.sv
////////////////////
// C16 memory top
// Loader, RAM arbiter and ROM bank behind plain ports
////////////////////
`timescale 1ns/1ps

module c16_mem_top (
	input  logic clk_sys,
	input  logic reset,
	input  logic model_i,
	input  logic cpu_req_i,
	input  logic cpu_we_i,
	input  c16_bus_pkg::addr_t cpu_addr_i,
	input  c16_bus_pkg::data_t cpu_wdata_i,
	input  logic dl_active_i,
	input  c16_bus_pkg::data_t dl_index_i,
	input  logic dl_valid_i,
	input  c16_bus_pkg::dl_addr_t dl_addr_i,
	input  c16_bus_pkg::data_t dl_data_i,
	output c16_bus_pkg::data_t cpu_rdata_o,
	output logic cpu_rvalid_o,
	output logic dl_wait_o,
	output logic loader_busy_o
);
	import c16_bus_pkg::*;

	cpu_bus_if cpu_bus ();
	mem_req_if mem_req ();

	data_t ram_rdata;
	data_t rom_rdata;
	logic rom_vis;

	// Master side of the CPU bus
	assign cpu_bus.req = cpu_req_i;
	assign cpu_bus.we = cpu_we_i;
	assign cpu_bus.addr = cpu_addr_i;
	assign cpu_bus.wdata = cpu_wdata_i;

	prg_loader u_loader (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_valid_i  (dl_valid_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.dl_wait_o   (dl_wait_o),
		.busy_o      (loader_busy_o),
		.req         (mem_req.loader)
	);

	ram_arbiter u_arbiter (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu       (cpu_bus.slave),
		.req       (mem_req.arbiter),
		.rdata_o   (ram_rdata),
		.rom_vis_o (rom_vis)
	);

	rom_bank u_rom (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.model_i    (model_i),
		.dl_index_i (dl_index_i),
		.dl_valid_i (dl_valid_i),
		.dl_addr_i  (dl_addr_i),
		.dl_data_i  (dl_data_i),
		.rom_vis_i  (rom_vis),
		.cpu        (cpu_bus.slave),
		.rdata_o    (rom_rdata)
	);

	// Unselected sources give all ones
	assign cpu_rdata_o = ram_rdata & rom_rdata;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cpu_rvalid_o <= 1'b0;
		end else begin
			cpu_rvalid_o <= cpu_req_i && !cpu_we_i;
		end
	end

endmodule

//--- test/c16_mem_sva.sv
////////////////////
// Loader queue and read checks
// Bound into the RAM arbiter
////////////////////
`timescale 1ns/1ps

module c16_mem_sva (
	input logic clk_sys,
	input logic reset,
	input logic valid_i,
	input c16_bus_pkg::credit_t q_count_i,
	input logic cpu_rd_i,
	input logic rvalid_i
);
	import c16_bus_pkg::*;

	// Queue depth mirrors the credits the loader has spent
	valid_needs_credit: assert property (@(posedge clk_sys) disable iff (reset)
		valid_i |-> (q_count_i < LOADER_CREDITS))
		else $error("loader write sent with no credit left");

	queue_bounded: assert property (@(posedge clk_sys) disable iff (reset)
		q_count_i <= LOADER_CREDITS)
		else $error("more loader writes outstanding than credits");

	// Top level read strobe follows each read request by one cycle
	rvalid_after_read: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_rd_i |=> rvalid_i)
		else $error("read valid missing one cycle after a read request");

	rvalid_only_after_read: assert property (@(posedge clk_sys) disable iff (reset)
		!cpu_rd_i |=> !rvalid_i)
		else $error("read valid raised without a read request the cycle before");

endmodule

//--- test/tb_c16_mem.sv
////////////////////
// C16 memory testbench
// Runs the command file against the memory top level and
// compares every CPU read with the expected byte
////////////////////
`timescale 1ns/1ps

module tb_c16_mem;
	import c16_bus_pkg::*;
	import c16_map_pkg::*;

	logic clk_sys;
	logic reset;
	logic model_i;
	logic cpu_req_i;
	logic cpu_we_i;
	addr_t cpu_addr_i;
	data_t cpu_wdata_i;
	logic dl_active_i;
	data_t dl_index_i;
	logic dl_valid_i;
	dl_addr_t dl_addr_i;
	data_t dl_data_i;
	data_t cpu_rdata_o;
	logic cpu_rvalid_o;
	logic dl_wait_o;
	logic loader_busy_o;

	logic [15:0] lfsr = 16'd4389;
	int cycles = 0;
	int limit = 1000;

	c16_mem_top dut (.*);

	bind ram_arbiter c16_mem_sva u_sva (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.valid_i   (req.valid),
		.q_count_i (q_count),
		.cpu_rd_i  (cpu_rd),
		.rvalid_i  (tb_c16_mem.dut.cpu_rvalid_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Watchdog sized from the command count
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout: the run went past %0d cycles", limit);
			$display("TEST RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = (v << 1) | lfsr[0];
		end
	endtask

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("ERR time=%0t %s got %h expected %h", $time, name, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic apply_reset();
		@(posedge clk_sys);
		reset <= 1'b1;
		dl_active_i <= 1'b0;
		dl_valid_i <= 1'b0;
		cpu_req_i <= 1'b0;
		cpu_we_i <= 1'b0;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		check("dl_wait_o", dl_wait_o, 0);
		check("loader_busy_o", loader_busy_o, 0);
		check("cpu_rvalid_o", cpu_rvalid_o, 0);
	endtask

	////////////////////
	// Host download
	// Stall reads keep the RAM port busy so loader writes pile up
	task automatic download_byte(input data_t idx, input dl_addr_t ofs, input data_t val);
		int gap;
		take_bits(2, gap);
		repeat (gap) begin
			@(posedge clk_sys);
			cpu_req_i <= 1'b1;
			cpu_we_i <= 1'b0;
			cpu_addr_i <= 16'h1000;
		end
		@(posedge clk_sys);
		dl_active_i <= 1'b1;
		dl_index_i <= idx;
		dl_valid_i <= 1'b1;
		dl_addr_i <= ofs;
		dl_data_i <= val;
		cpu_req_i <= 1'b1;
		cpu_we_i <= 1'b0;
		cpu_addr_i <= 16'h1000;
		@(negedge clk_sys);
		// Release the RAM port while the host is held off
		while (dl_wait_o) begin
			@(posedge clk_sys);
			cpu_req_i <= 1'b0;
			@(negedge clk_sys);
		end
		@(posedge clk_sys);
		dl_valid_i <= 1'b0;
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		dl_active_i <= 1'b0;
		dl_valid_i <= 1'b0;
		cpu_req_i <= 1'b0;
		@(negedge clk_sys);
		while (loader_busy_o) begin
			@(negedge clk_sys);
		end
	endtask

	////////////////////
	// CPU accesses
	task automatic cpu_write(input addr_t a, input data_t d);
		@(posedge clk_sys);
		cpu_req_i <= 1'b1;
		cpu_we_i <= 1'b1;
		cpu_addr_i <= a;
		cpu_wdata_i <= d;
		@(posedge clk_sys);
		cpu_req_i <= 1'b0;
		cpu_we_i <= 1'b0;
	endtask

	task automatic cpu_read(input addr_t a, input data_t exp);
		@(posedge clk_sys);
		cpu_req_i <= 1'b1;
		cpu_we_i <= 1'b0;
		cpu_addr_i <= a;
		@(posedge clk_sys);
		cpu_req_i <= 1'b0;
		@(negedge clk_sys);
		check("cpu_rvalid_o", cpu_rvalid_o, 1);
		check("cpu_rdata_o", cpu_rdata_o, exp);
	endtask

	initial begin
		string line;
		string cmds [$];
		int fd;
		int n;
		byte cmd;
		int f1;
		int f2;
		int f3;
		reset = 1'b1;
		model_i = 1'b0;
		cpu_req_i = 1'b0;
		cpu_we_i = 1'b0;
		cpu_addr_i = '0;
		cpu_wdata_i = '0;
		dl_active_i = 1'b0;
		dl_index_i = '0;
		dl_valid_i = 1'b0;
		dl_addr_i = '0;
		dl_data_i = '0;
		fd = $fopen("test/c16_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test data file");
			$display("TEST RESULT: FAIL");
			$fatal(1, "no test data");
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if ((n > 1) && (line.getc(0) != "#")) begin
				cmds.push_back(line);
			end
		end
		$fclose(fd);
		limit = cmds.size() * 64 + 1000;
		apply_reset();
		foreach (cmds[i]) begin
			f1 = 0;
			f2 = 0;
			f3 = 0;
			n = $sscanf(cmds[i], "%c %h %h %h", cmd, f1, f2, f3);
			case (cmd)
				"M": model_i <= f1[0];
				"X": apply_reset();
				"L": download_byte(f1[7:0], f2[24:0], f3[7:0]);
				"E": end_download();
				"W": cpu_write(f1[15:0], f2[7:0]);
				"R": cpu_read(f1[15:0], f2[7:0]);
				default: begin
					$display("Unknown command in the test data: %s", cmds[i]);
					$display("TEST RESULT: FAIL");
					$fatal(1, "bad command");
				end
			endcase
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- test/c16_testdata.txt
# Columns, hex: M model | X | L index offset byte | E | W addr byte | R addr expected
# L offset is the 25-bit download offset, block number in bits 24..14
# ROM download: BASIC 8000, kernal FC10 and C000, function low 8000, high C000
L 03 08000 B1
L 03 07C10 4C
L 03 04000 E0
L 03 0C000 F1
L 03 10000 F2
E
R 8000 B1
R FC10 4C
# RAM under ROM and the ROM on/off writes
W 8000 55
R 8000 B1
W FF3F 00
R 8000 55
W FF3E 00
R 8000 B1
R FD20 FF
# Bank write is ignored by the C16 model
W FDDA 00
R 8000 B1
R C000 E0
# Plus/4 model, both fields set to function ROM
M 1
X
W FDDA 00
R 8000 F1
R C000 F2
R FC10 4C
# Low field on cartridge
W FDD1 00
R 8000 FF
L 81 00000 A5
E
R 8000 A5
X
W FDD1 00
R 8000 FF
# PRG at 3000 with six data bytes, end address 3006
L 01 00000 00
L 01 00001 30
L 01 00002 11
L 01 00003 22
L 01 00004 33
L 01 00005 44
L 01 00006 55
L 01 00007 66
E
R 3000 11
R 3001 22
R 3002 33
R 3003 44
R 3004 55
R 3005 66
R 002D 06
R 002E 30
R 002F 06
R 0030 30
R 0031 06
R 0032 30
R 009D 06
R 009E 30

//--- build.f
design/c16_bus_pkg.sv
design/c16_map_pkg.sv
design/cpu_bus_if.sv
design/mem_req_if.sv
design/prg_loader.sv
design/ram_arbiter.sv
design/rom_bank.sv
design/c16_mem_top.sv
test/c16_mem_sva.sv
test/tb_c16_mem.sv

//--- Makefile
# Verilator build and run of the C16 memory testbench
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module tb_c16_mem -Mdir obj_dir -o sim_c16
	./obj_dir/sim_c16 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
